// File: common/mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int data_w = 32; // Machine word
	localparam int reg_addr_w = 5; // 32 GPRs

	// First fetch address after reset
	localparam logic [data_w-1:0] reset_pc = '0;

	// Primary opcode field, inst[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'h00, // Uses funct
		op_beq = 6'h04,
		op_addi = 6'h08,
		op_lw = 6'h23,
		op_sw = 6'h2b
	} opcode_e;

	// R-type function field, inst[5:0]
	typedef enum logic [5:0] {
		fn_add = 6'h20
	} funct_e;

	// ALU selection
	typedef enum logic [1:0] {
		alu_add = 2'b00, // Address calc and ADDI
		alu_sub = 2'b01, // BEQ compare
		alu_funct = 2'b10 // Decided by funct
	} aluop_e;

	// Decoded control bits, 9 bits total
	typedef struct packed {
		logic regwrite;
		logic memtoreg; // Writeback from data bus
		logic memread;
		logic memwrite;
		logic isbranch;
		logic regdst; // 1 selects rd, 0 selects rt
		aluop_e aluop;
		logic alusrc; // 1 selects the immediate
	} ctrl_t;

	// Bubble and unknown encodings
	localparam ctrl_t nop_ctrl = '{
		regwrite: 1'b0,
		memtoreg: 1'b0,
		memread: 1'b0,
		memwrite: 1'b0,
		isbranch: 1'b0,
		regdst: 1'b0,
		aluop: alu_add,
		alusrc: 1'b0
	};

endpackage

`default_nettype wire

// File: common/decode_exec_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decode/execute pipeline register contents
interface decode_exec_if;
	logic valid; // Low for bubbles
	mips_pkg::ctrl_t ctrl;
	logic [mips_pkg::data_w-1:0] pc; // Address of this instruction
	logic [mips_pkg::data_w-1:0] rs_val;
	logic [mips_pkg::data_w-1:0] rt_val;
	logic [mips_pkg::data_w-1:0] imm; // Already sign extended
	logic [mips_pkg::reg_addr_w-1:0] dest;

	modport src(
		output valid, ctrl, pc, rs_val, rt_val, imm, dest
	);

	modport dst(
		input valid, ctrl, pc, rs_val, rt_val, imm, dest
	);
endinterface

`default_nettype wire

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input logic clk,
	input logic reset,
	input logic stall, // Decode cannot take a word
	input logic redirect,
	input logic [mips_pkg::data_w-1:0] redirect_pc,
	output logic iwb_cyc,
	output logic iwb_stb,
	output logic [mips_pkg::data_w-1:0] iwb_adr,
	input logic [mips_pkg::data_w-1:0] iwb_dat_i,
	input logic iwb_ack,
	output logic inst_valid,
	output logic [mips_pkg::data_w-1:0] inst,
	output logic [mips_pkg::data_w-1:0] inst_pc
);

	logic [mips_pkg::data_w-1:0] pc; // Next address to fetch
	logic [mips_pkg::data_w-1:0] pc_next;
	logic [mips_pkg::data_w-1:0] buf_inst;
	logic [mips_pkg::data_w-1:0] buf_pc;
	logic buf_valid; // One-entry hold buffer
	logic stale; // In-flight word belongs to the flushed path
	logic fetch_hit; // Useful word on the bus this cycle
	logic fetch_ok;

	assign iwb_stb = iwb_cyc;
	assign fetch_hit = iwb_cyc && iwb_ack && !stale;
	assign fetch_ok = !buf_valid || !stall || redirect; // Room for one more word

	always_comb begin
		pc_next = pc;
		if (redirect)
			pc_next = redirect_pc; // Branch target wins
		else if (fetch_hit)
			pc_next = pc + 32'd4;
	end

	// Buffer first to keep program order
	assign inst_valid = buf_valid || fetch_hit;
	assign inst = buf_valid ? buf_inst : iwb_dat_i;
	assign inst_pc = buf_valid ? buf_pc : iwb_adr;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= mips_pkg::reset_pc;
			iwb_cyc <= 1'b0;
			buf_valid <= 1'b0;
			stale <= 1'b0;
		end else begin
			pc <= pc_next;
			if (iwb_cyc && iwb_ack)
				iwb_cyc <= 1'b0; // Idle at least one cycle
			else if (!iwb_cyc && fetch_ok)
				iwb_cyc <= 1'b1;
			if (redirect && iwb_cyc && !iwb_ack)
				stale <= 1'b1; // Finish the cycle and drop the word
			else if (iwb_ack)
				stale <= 1'b0;
			if (redirect)
				buf_valid <= 1'b0;
			else if (fetch_hit && stall)
				buf_valid <= 1'b1; // Park it while decode is busy
			else if (buf_valid && !stall)
				buf_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!iwb_cyc && fetch_ok)
			iwb_adr <= pc_next; // Held for the whole bus cycle
		if (fetch_hit && stall) begin
			buf_inst <= iwb_dat_i;
			buf_pc <= iwb_adr;
		end
	end

	// A parked word is never overrun by a new fetch
	a_no_overrun: assert property (@(posedge clk) disable iff (reset)
		buf_valid |-> !fetch_hit);
	a_adr_hold: assert property (@(posedge clk) disable iff (reset)
		iwb_stb && !iwb_ack |=> $stable(iwb_adr));

endmodule

`default_nettype wire

// File: decode/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

// Purely combinational, no state
module control_unit (
	input logic [5:0] opcode,
	input logic [5:0] funct,
	output mips_pkg::ctrl_t ctrl
);

	always_comb begin
		ctrl = mips_pkg::nop_ctrl; // Anything unlisted has no effect
		case (mips_pkg::opcode_e'(opcode))
			mips_pkg::op_rtype: begin
				case (mips_pkg::funct_e'(funct))
					mips_pkg::fn_add: begin
						ctrl.regwrite = 1'b1;
						ctrl.regdst = 1'b1; // Result to rd
						ctrl.aluop = mips_pkg::alu_funct;
					end
					default: ctrl = mips_pkg::nop_ctrl;
				endcase
			end
			mips_pkg::op_addi: begin
				ctrl.regwrite = 1'b1;
				ctrl.aluop = mips_pkg::alu_add;
				ctrl.alusrc = 1'b1;
			end
			mips_pkg::op_lw: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1; // Load data, not the address
				ctrl.memread = 1'b1;
				ctrl.aluop = mips_pkg::alu_add;
				ctrl.alusrc = 1'b1;
			end
			mips_pkg::op_sw: begin
				ctrl.memwrite = 1'b1;
				ctrl.aluop = mips_pkg::alu_add;
				ctrl.alusrc = 1'b1; // Base plus offset
			end
			mips_pkg::op_beq: begin
				ctrl.isbranch = 1'b1;
				ctrl.aluop = mips_pkg::alu_sub; // Zero result means equal
			end
			default: ctrl = mips_pkg::nop_ctrl;
		endcase
	end

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	input logic [mips_pkg::data_w-1:0] inst,
	input logic [mips_pkg::data_w-1:0] inst_pc,
	input logic stall_in, // Memory stage busy
	output logic stall_out,
	input logic flush, // Taken branch in execute
	input logic ex_dest_valid,
	input logic [mips_pkg::reg_addr_w-1:0] ex_dest,
	input logic mem_dest_valid,
	input logic [mips_pkg::reg_addr_w-1:0] mem_dest,
	input logic wb_en,
	input logic [mips_pkg::reg_addr_w-1:0] wb_addr,
	input logic [mips_pkg::data_w-1:0] wb_data,
	decode_exec_if.src de
);

	logic [mips_pkg::data_w-1:0] regs [32];
	logic if_valid; // Fetch/decode register
	logic [mips_pkg::data_w-1:0] if_inst;
	logic [mips_pkg::data_w-1:0] if_pc;
	logic [mips_pkg::reg_addr_w-1:0] rs, rt, rd;
	logic [mips_pkg::data_w-1:0] rs_val, rt_val;
	logic hazard;
	mips_pkg::ctrl_t ctrl;

	// Register 0 reads as zero, same-cycle writeback passes through
	function automatic logic [mips_pkg::data_w-1:0] read_reg(
		input logic [mips_pkg::reg_addr_w-1:0] a);
		if (a == '0)
			return '0;
		else if (wb_en && wb_addr == a)
			return wb_data;
		else
			return regs[a];
	endfunction

	assign rs = if_inst[25:21];
	assign rt = if_inst[20:16];
	assign rd = if_inst[15:11];

	control_unit i_control_unit (.opcode(if_inst[31:26]), .funct(if_inst[5:0]), .ctrl(ctrl));

	always_comb begin
		rs_val = read_reg(rs);
		rt_val = read_reg(rt);
		hazard = 1'b0;
		if (if_valid && rs != '0)
			hazard = (ex_dest_valid && ex_dest == rs) || (mem_dest_valid && mem_dest == rs);
		if (if_valid && rt != '0 && ((ex_dest_valid && ex_dest == rt) ||
			(mem_dest_valid && mem_dest == rt)))
			hazard = 1'b1; // RAW on rt
	end

	assign stall_out = stall_in || hazard;

	always_ff @(posedge clk) begin
		if (wb_en)
			regs[wb_addr] <= wb_data;
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			if_valid <= 1'b0;
			de.valid <= 1'b0;
			de.ctrl <= mips_pkg::nop_ctrl;
		end else if (!stall_in) begin
			if (hazard) begin
				de.valid <= 1'b0; // Bubble, hold fetch/decode
				de.ctrl <= mips_pkg::nop_ctrl;
			end else begin
				de.valid <= if_valid;
				de.ctrl <= if_valid ? ctrl : mips_pkg::nop_ctrl;
				if_valid <= inst_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_out) begin
			if_inst <= inst;
			if_pc <= inst_pc;
			de.pc <= if_pc;
			de.rs_val <= rs_val;
			de.rt_val <= rt_val;
			de.imm <= {{16{if_inst[15]}}, if_inst[15:0]}; // Sign extend
			de.dest <= ctrl.regdst ? rd : rt;
		end
	end

	a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
		wb_en |-> wb_addr != '0);

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input logic clk,
	input logic reset,
	decode_exec_if.dst de,
	input logic stall_in,
	output logic redirect,
	output logic [mips_pkg::data_w-1:0] redirect_pc,
	output logic dest_valid,
	output logic [mips_pkg::reg_addr_w-1:0] dest,
	output logic mem_valid,
	output mips_pkg::ctrl_t mem_ctrl,
	output logic [mips_pkg::data_w-1:0] alu_result,
	output logic [mips_pkg::data_w-1:0] store_val,
	output logic [mips_pkg::reg_addr_w-1:0] mem_dest
);

	logic [mips_pkg::data_w-1:0] op_b;
	logic [mips_pkg::data_w-1:0] result;

	assign op_b = de.ctrl.alusrc ? de.imm : de.rt_val;

	always_comb begin
		case (de.ctrl.aluop)
			mips_pkg::alu_sub: result = de.rs_val - op_b; // BEQ compare
			default: result = de.rs_val + op_b; // ADD, ADDI and address calc
		endcase
	end

	// Resolve only when the branch moves on so redirect lasts one cycle
	assign redirect = de.valid && de.ctrl.isbranch && result == '0 && !stall_in;
	assign redirect_pc = de.pc + 32'd4 + {de.imm[29:0], 2'b00};

	assign dest_valid = de.valid && de.ctrl.regwrite; // Feeds the interlock
	assign dest = de.dest;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_valid <= 1'b0;
			mem_ctrl <= mips_pkg::nop_ctrl;
		end else if (!stall_in) begin
			mem_valid <= de.valid;
			mem_ctrl <= de.ctrl;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_in) begin
			alu_result <= result;
			store_val <= de.rt_val; // SW data
			mem_dest <= de.dest;
		end
	end

	a_redirect_pulse: assert property (@(posedge clk) disable iff (reset)
		redirect |=> !redirect);

endmodule

`default_nettype wire

// File: rtl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input logic clk,
	input logic reset,
	input logic mem_valid,
	input mips_pkg::ctrl_t mem_ctrl,
	input logic [mips_pkg::data_w-1:0] alu_result,
	input logic [mips_pkg::data_w-1:0] store_val,
	input logic [mips_pkg::reg_addr_w-1:0] mem_dest,
	output logic stall_out,
	output logic dwb_cyc,
	output logic dwb_stb,
	output logic dwb_we,
	output logic [mips_pkg::data_w-1:0] dwb_adr,
	output logic [mips_pkg::data_w-1:0] dwb_dat_o,
	output logic [3:0] dwb_sel,
	input logic [mips_pkg::data_w-1:0] dwb_dat_i,
	input logic dwb_ack,
	output logic wb_en,
	output logic [mips_pkg::reg_addr_w-1:0] wb_addr,
	output logic [mips_pkg::data_w-1:0] wb_data,
	output logic dest_valid,
	output logic [mips_pkg::reg_addr_w-1:0] dest
);

	logic access; // LW or SW in this stage
	logic done; // Instruction leaves at this edge

	assign access = mem_valid && (mem_ctrl.memread || mem_ctrl.memwrite);
	assign done = !access || (dwb_cyc && dwb_ack);
	assign stall_out = !done;

	// Address and data come from the held execute/memory register
	assign dwb_stb = dwb_cyc;
	assign dwb_we = mem_ctrl.memwrite;
	assign dwb_adr = alu_result;
	assign dwb_dat_o = store_val;
	assign dwb_sel = 4'hf; // Word access only

	always_ff @(posedge clk) begin
		if (reset)
			dwb_cyc <= 1'b0;
		else if (dwb_cyc && dwb_ack)
			dwb_cyc <= 1'b0;
		else if (access)
			dwb_cyc <= 1'b1;
	end

	// Writeback on the ack edge or the pass edge
	assign wb_en = mem_valid && mem_ctrl.regwrite && done && mem_dest != '0;
	assign wb_addr = mem_dest;
	assign wb_data = mem_ctrl.memtoreg ? dwb_dat_i : alu_result;

	// A completing write is covered by regfile write-through
	assign dest_valid = mem_valid && mem_ctrl.regwrite && !done;
	assign dest = mem_dest;

	a_we_stable: assert property (@(posedge clk) disable iff (reset)
		dwb_stb && !dwb_ack |=> $stable(dwb_we));

endmodule

`default_nettype wire

// File: rtl/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
	input logic clk,
	input logic reset,
	output logic iwb_cyc,
	output logic iwb_stb,
	output logic [mips_pkg::data_w-1:0] iwb_adr,
	input logic [mips_pkg::data_w-1:0] iwb_dat_i,
	input logic iwb_ack,
	output logic dwb_cyc,
	output logic dwb_stb,
	output logic dwb_we,
	output logic [mips_pkg::data_w-1:0] dwb_adr,
	output logic [mips_pkg::data_w-1:0] dwb_dat_o,
	output logic [3:0] dwb_sel,
	input logic [mips_pkg::data_w-1:0] dwb_dat_i,
	input logic dwb_ack
);

	logic inst_valid, dec_stall, mem_stall;
	logic [mips_pkg::data_w-1:0] inst, inst_pc;
	logic redirect; // Taken BEQ, also the flush
	logic [mips_pkg::data_w-1:0] redirect_pc;
	logic ex_dest_valid, md_valid, em_valid;
	logic [mips_pkg::reg_addr_w-1:0] ex_dest, md_dest, em_dest;
	mips_pkg::ctrl_t em_ctrl;
	logic [mips_pkg::data_w-1:0] em_result, em_store;
	logic wb_en;
	logic [mips_pkg::reg_addr_w-1:0] wb_addr;
	logic [mips_pkg::data_w-1:0] wb_data;

	decode_exec_if de_bus ();

	fetch_stage i_fetch (.clk, .reset, .stall(dec_stall), .redirect, .redirect_pc,
		.iwb_cyc, .iwb_stb, .iwb_adr, .iwb_dat_i, .iwb_ack, .inst_valid, .inst, .inst_pc);

	decode_stage i_decode (.clk, .reset, .inst_valid, .inst, .inst_pc,
		.stall_in(mem_stall), .stall_out(dec_stall), .flush(redirect),
		.ex_dest_valid, .ex_dest, .mem_dest_valid(md_valid), .mem_dest(md_dest),
		.wb_en, .wb_addr, .wb_data, .de(de_bus.src));

	execute_stage i_execute (.clk, .reset, .de(de_bus.dst), .stall_in(mem_stall),
		.redirect, .redirect_pc, .dest_valid(ex_dest_valid), .dest(ex_dest),
		.mem_valid(em_valid), .mem_ctrl(em_ctrl), .alu_result(em_result),
		.store_val(em_store), .mem_dest(em_dest));

	memory_stage i_memory (.clk, .reset, .mem_valid(em_valid), .mem_ctrl(em_ctrl),
		.alu_result(em_result), .store_val(em_store), .mem_dest(em_dest),
		.stall_out(mem_stall), .dwb_cyc, .dwb_stb, .dwb_we, .dwb_adr, .dwb_dat_o,
		.dwb_sel, .dwb_dat_i, .dwb_ack, .wb_en, .wb_addr, .wb_data,
		.dest_valid(md_valid), .dest(md_dest));

endmodule

`default_nettype wire

// File: verif/tb_mips_ref.svh
`ifndef TB_MIPS_REF_SVH
`define TB_MIPS_REF_SVH

// Program words are built from MIPS field layouts
function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
	input logic [4:0] rd, input logic [5:0] funct);
	return {6'h00, rs, rt, rd, 5'd0, funct};
endfunction

task automatic add_word(input logic [31:0] w);
	imem[prog_len] = w;
	prog_len++;
endtask

// Each program ends in BEQ $0,$0,-1
task automatic load_program(input int n);
	for (int i = 0; i < 64; i++)
		imem[i] = imem_fill(i * 4); // Unknown opcode 0x3f everywhere else
	prog_len = 0;
	case (n)
		0: begin // Back-to-back ALU dependencies
			add_word(i_type(6'h08, 0, 1, 5)); // addi r1, r0, 5
			add_word(i_type(6'h08, 1, 2, 7)); // addi r2, r1, 7
			add_word(r_type(1, 2, 3, 6'h20)); // add r3, r1, r2
			add_word(r_type(3, 3, 3, 6'h20));
			add_word(i_type(6'h08, 3, 4, -20));
			add_word(i_type(6'h2b, 0, 3, 16'h0100)); // sw r3, 0x100(r0)
			add_word(i_type(6'h2b, 0, 4, 16'h0104));
			add_word(r_type(4, 1, 5, 6'h20));
			add_word(i_type(6'h2b, 0, 5, 16'h0108));
		end
		1: begin // Load followed by its user
			add_word(i_type(6'h23, 0, 1, 16'h0140)); // lw r1, 0x140(r0)
			add_word(r_type(1, 1, 2, 6'h20));
			add_word(i_type(6'h2b, 0, 2, 16'h0110));
			add_word(i_type(6'h08, 0, 3, 16'h0033));
			add_word(i_type(6'h2b, 0, 3, 16'h0144));
			add_word(i_type(6'h23, 0, 4, 16'h0144)); // Reads back the store
			add_word(r_type(4, 2, 5, 6'h20));
			add_word(i_type(6'h2b, 0, 5, 16'h0114));
		end
		2: begin
			add_word(i_type(6'h08, 0, 1, 3));
			add_word(i_type(6'h08, 0, 2, 3));
			add_word(i_type(6'h04, 1, 2, 2)); // Taken, skips two stores
			add_word(i_type(6'h2b, 0, 1, 16'h0120)); // Shadow slot
			add_word(i_type(6'h2b, 0, 2, 16'h0124)); // Shadow slot
			add_word(i_type(6'h2b, 0, 1, 16'h0128));
			add_word(i_type(6'h08, 0, 3, 4));
			add_word(i_type(6'h04, 1, 3, 2)); // Not taken
			add_word(i_type(6'h2b, 0, 3, 16'h012c));
			add_word(i_type(6'h2b, 0, 1, 16'h0130));
		end
		default: begin // Register 0 writes and unknown encodings
			add_word(i_type(6'h08, 0, 0, 9)); // addi r0, r0, 9
			add_word(i_type(6'h08, 0, 1, 6));
			add_word(r_type(1, 1, 0, 6'h20)); // add r0, r1, r1
			add_word(32'hfc21_0000); // Opcode 0x3f naming r1
			add_word(r_type(1, 1, 1, 6'h22)); // SUB is not supported
			add_word(i_type(6'h20, 0, 1, 16'h0150)); // LB is not supported
			add_word(i_type(6'h2b, 0, 0, 16'h0150));
			add_word(i_type(6'h2b, 0, 1, 16'h0154));
			add_word(r_type(0, 1, 2, 6'h20));
			add_word(i_type(6'h2b, 0, 2, 16'h0158));
		end
	endcase
	add_word(i_type(6'h04, 0, 0, 16'hffff)); // Self loop
endtask

// Instruction-set model, fills the expected store queues
function automatic void ref_run();
	logic [31:0] regs [32];
	logic [31:0] mem [256];
	logic [31:0] pc, next_pc, inst, imm, a;
	logic [4:0] rs, rt, rd;
	bit stop;
	int steps;
	for (int i = 0; i < 32; i++)
		regs[i] = '0;
	for (int i = 0; i < 256; i++)
		mem[i] = dmem_fill(i * 4);
	pc = '0;
	stop = 1'b0;
	steps = 0;
	while (!stop && steps < 500) begin
		inst = imem[pc[7:2]];
		rs = inst[25:21];
		rt = inst[20:16];
		rd = inst[15:11];
		imm = {{16{inst[15]}}, inst[15:0]};
		a = regs[rs] + imm;
		next_pc = pc + 4;
		case (inst[31:26])
			6'h00: if (inst[5:0] == 6'h20) regs[rd] = regs[rs] + regs[rt];
			6'h08: regs[rt] = a; // ADDI
			6'h23: regs[rt] = mem[a[9:2]];
			6'h2b: begin
				mem[a[9:2]] = regs[rt];
				exp_adr.push_back(a);
				exp_dat.push_back(regs[rt]);
			end
			6'h04: if (regs[rs] == regs[rt]) next_pc = pc + 4 + (imm << 2);
			default: ; // No effect
		endcase
		regs[0] = '0;
		stop = next_pc == pc;
		pc = next_pc;
		steps++;
	end
endfunction

`endif

// File: verif/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

	logic clk;
	logic reset;
	logic iwb_cyc, iwb_stb, iwb_ack;
	logic [31:0] iwb_adr, iwb_dat_i;
	logic dwb_cyc, dwb_stb, dwb_we, dwb_ack;
	logic [31:0] dwb_adr, dwb_dat_o, dwb_dat_i;
	logic [3:0] dwb_sel;

	logic [31:0] imem [64];
	logic [31:0] dmem [256];
	int prog_len;
	logic [31:0] exp_adr [$]; // Expected stores in program order
	logic [31:0] exp_dat [$];
	logic [31:0] exp_a, exp_d;
	logic [31:0] lfsr;
	bit rand_acks; // Zero ack delay until the last test
	int i_wait, d_wait; // Remaining ack delay, -1 when idle
	int errors, pass_count, fail_count;

	mips_core i_dut (.clk, .reset, .iwb_cyc, .iwb_stb, .iwb_adr, .iwb_dat_i, .iwb_ack,
		.dwb_cyc, .dwb_stb, .dwb_we, .dwb_adr, .dwb_dat_o, .dwb_sel, .dwb_dat_i, .dwb_ack);

	// Odd multiplier spreads every address bit
	function automatic logic [31:0] dmem_fill(input logic [31:0] a);
		return (a * 32'h9e37_79b9) ^ 32'h0bad_cafe;
	endfunction

	function automatic logic [31:0] imem_fill(input logic [31:0] a);
		return 32'hfc00_0000 | ((a * 32'h9e37_79b9) >> 6);
	endfunction

	`include "tb_mips_ref.svh"

	// Galois LFSR, taps 32 30 26 25
	function automatic logic next_rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'ha300_0000;
		return b;
	endfunction

	function automatic int ack_delay();
		int d;
		if (!rand_acks)
			return 0;
		d = next_rand_bit();
		d = d * 2 + next_rand_bit();
		return d;
	endfunction

	always #4 clk = ~clk;

	// Both slaves in one block so the LFSR order is fixed
	always @(posedge clk) begin
		#1;
		if (reset || iwb_ack) begin
			iwb_ack = 1'b0;
			i_wait = -1;
		end else if (iwb_cyc && iwb_stb) begin
			if (i_wait < 0)
				i_wait = ack_delay();
			if (i_wait == 0) begin
				iwb_ack = 1'b1;
				iwb_dat_i = imem[iwb_adr[7:2]];
				i_wait = -1;
			end else
				i_wait--;
		end
		if (reset || dwb_ack) begin
			dwb_ack = 1'b0;
			d_wait = -1;
		end else if (dwb_cyc && dwb_stb) begin
			if (d_wait < 0)
				d_wait = ack_delay();
			if (d_wait == 0) begin
				dwb_ack = 1'b1;
				if (dwb_we)
					dmem[dwb_adr[9:2]] = dwb_dat_o;
				else
					dwb_dat_i = dmem[dwb_adr[9:2]];
				d_wait = -1;
			end else
				d_wait--;
		end
	end

	// Store checker, samples mid-cycle where all bus signals are settled
	always @(negedge clk) begin
		if (!reset && dwb_cyc && dwb_stb && dwb_we && dwb_ack) begin
			assert (exp_adr.size() != 0) else begin
				$display("Unexpected store to %h at %0t after the last expected one",
					dwb_adr, $time);
				errors++;
			end
			if (exp_adr.size() != 0) begin
				exp_a = exp_adr.pop_front();
				exp_d = exp_dat.pop_front();
				assert (dwb_adr == exp_a) else begin
					$display("FAILED %0t dwb_adr got %h expected %h", $time, dwb_adr, exp_a);
					errors++;
				end
				assert (dwb_dat_o == exp_d) else begin
					$display("FAILED %0t dwb_dat_o got %h expected %h", $time, dwb_dat_o,
						exp_d);
					errors++;
				end
				assert (dwb_sel == 4'hf) else begin
					$display("FAILED %0t dwb_sel got %h expected f", $time, dwb_sel);
					errors++;
				end
			end
		end
	end

	task automatic end_run();
		$display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	// Program set up under reset, so no stale fetch reaches the bus
	task automatic run_program(input int n);
		int cycles;
		int limit;
		@(posedge clk);
		#1 reset = 1'b1;
		load_program(n);
		for (int i = 0; i < 256; i++)
			dmem[i] = dmem_fill(i * 4);
		exp_adr.delete();
		exp_dat.delete();
		ref_run();
		limit = prog_len * 12 + 40; // Worst stall chain per word plus margin
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		cycles = 0;
		while (exp_adr.size() != 0) begin
			@(posedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("Program %0d timed out waiting for stores, %0d still expected",
					n, exp_adr.size());
				fail_count++;
				end_run();
			end
		end
		repeat (50) @(posedge clk); // Extra stores show up in the checker
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		if (errors == errs_before) begin
			pass_count++;
			$display("Test %0d %s: passed", num, name);
		end else begin
			fail_count++;
			$display("Test %0d %s: failed with %0d errors", num, name, errors - errs_before);
		end
	endtask

	initial begin
		int errs_before;
		clk = 1'b0;
		reset = 1'b1;
		iwb_ack = 1'b0;
		iwb_dat_i = '0;
		dwb_ack = 1'b0;
		dwb_dat_i = '0;
		lfsr = 32'hd973_9bcd;
		rand_acks = 1'b0;
		i_wait = -1;
		d_wait = -1;
		errors = 0;
		pass_count = 0;
		fail_count = 0;
		errs_before = errors;
		run_program(0);
		report_test(1, "ALU chain and interlock", errs_before);
		errs_before = errors;
		run_program(1);
		report_test(2, "load use", errs_before);
		errs_before = errors;
		run_program(2);
		report_test(3, "branches and flush", errs_before);
		errs_before = errors;
		run_program(3);
		report_test(4, "register 0 and unknown opcodes", errs_before);
		rand_acks = 1'b1;
		errs_before = errors;
		for (int t = 0; t < 4; t++)
			run_program(t);
		report_test(5, "random ack delays", errs_before);
		end_run();
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+verif
common/mips_pkg.sv
common/decode_exec_if.sv
rtl/fetch_stage.sv
decode/control_unit.sv
decode/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/mips_core.sv
verif/tb_mips_core.sv
